// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= arith_unit_tb
FILELIST  ?= arith_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== arith_unit.f ====
+incdir+.
arith_unit_pkg.sv
float_fmt_pkg.sv
int_divider.sv
shift_add_multiplier.sv
float_adder.sv
float_multiplier.sv
arith_unit.sv
arith_unit_tb.sv

// ==== arith_unit.sv ====
module arith_unit (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 start,
    input  arith_unit_pkg::op_e                  op,
    input  logic [arith_unit_pkg::int_width-1:0] a,
    input  logic [arith_unit_pkg::int_width-1:0] b,
    output logic [arith_unit_pkg::int_width-1:0] result,
    output logic                                 ready
);

    arith_unit_pkg::op_e                  last_op;
    logic                                 div_start;
    logic                                 div_signed;
    logic                                 div_ready;
    logic [arith_unit_pkg::int_width-1:0] div_result;
    logic                                 add_start;
    logic                                 add_subtract;
    logic                                 add_ready;
    logic [arith_unit_pkg::int_width-1:0] add_result;
    logic                                 mul_start;
    logic                                 mul_ready;
    logic [arith_unit_pkg::int_width-1:0] mul_result;

    // start goes to one engine only.
    assign div_start = start && (op == arith_unit_pkg::op_divu || op == arith_unit_pkg::op_divs);
    assign div_signed = (op == arith_unit_pkg::op_divs);
    assign add_start = start && (op == arith_unit_pkg::op_fadd || op == arith_unit_pkg::op_fsub);
    assign add_subtract = (op == arith_unit_pkg::op_fsub);
    assign mul_start = start && (op == arith_unit_pkg::op_fmul);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_op <= arith_unit_pkg::op_divu;
        end else if (start) begin
            last_op <= op;
        end
    end

    int_divider u_div (
        .clk(clk),
        .arst_n(arst_n),
        .start(div_start),
        .is_signed(div_signed),
        .dividend(a),
        .divisor(b),
        .quotient(div_result),
        .ready(div_ready)
    );

    float_adder u_add (
        .clk(clk),
        .arst_n(arst_n),
        .start(add_start),
        .subtract(add_subtract),
        .a(a),
        .b(b),
        .sum(add_result),
        .ready(add_ready)
    );

    float_multiplier u_mul (
        .clk(clk),
        .arst_n(arst_n),
        .start(mul_start),
        .a(a),
        .b(b),
        .product(mul_result),
        .ready(mul_ready)
    );

    always_comb begin
        case (last_op)
            arith_unit_pkg::op_divu, arith_unit_pkg::op_divs: begin
                result = div_result;
                ready = div_ready;
            end
            arith_unit_pkg::op_fadd, arith_unit_pkg::op_fsub: begin
                result = add_result;
                ready = add_ready;
            end
            arith_unit_pkg::op_fmul: begin
                result = mul_result;
                ready = mul_ready;
            end
            default: begin
                result = '0;
                ready = 1'b1;
            end
        endcase
    end

    // one operation in flight.
    assert property (@(posedge clk) disable iff (!arst_n) start |-> ready);

endmodule

// ==== arith_unit_pkg.sv ====
package arith_unit_pkg;

    // operation codes seen at the top level.
    typedef enum logic [2:0] {
        op_divu,
        op_divs,
        op_fadd,
        op_fsub,
        op_fmul
    } op_e;

    localparam int int_width = 32;
    localparam int iter_count_width = 6;

endpackage

// ==== arith_unit_ref.svh ====
`ifndef arith_unit_ref_svh
`define arith_unit_ref_svh

// quotient truncated toward zero in signed mode.
function automatic logic [arith_unit_pkg::int_width-1:0] ref_divide(
    input arith_unit_pkg::op_e                  op,
    input logic [arith_unit_pkg::int_width-1:0] dividend,
    input logic [arith_unit_pkg::int_width-1:0] divisor
);
    logic                                 is_signed;
    logic                                 neg_n;
    logic                                 neg_d;
    logic [arith_unit_pkg::int_width-1:0] mag_n;
    logic [arith_unit_pkg::int_width-1:0] mag_d;
    logic [arith_unit_pkg::int_width-1:0] quo;
    is_signed = (op == arith_unit_pkg::op_divs);
    neg_n = is_signed && dividend[arith_unit_pkg::int_width-1];
    neg_d = is_signed && divisor[arith_unit_pkg::int_width-1];
    mag_n = neg_n ? -dividend : dividend;
    mag_d = neg_d ? -divisor : divisor;
    quo = mag_n / mag_d;
    return (neg_n ^ neg_d) ? -quo : quo;
endfunction

// truncating add, same step order as the adder.
function automatic logic [float_fmt_pkg::float_width-1:0] ref_float_add(
    input arith_unit_pkg::op_e                    op,
    input logic [float_fmt_pkg::float_width-1:0]  a,
    input logic [float_fmt_pkg::float_width-1:0]  b
);
    logic                                        sign_a;
    logic                                        sign_b;
    logic                                        sign_r;
    logic [float_fmt_pkg::exp_width-1:0]         exp_a;
    logic [float_fmt_pkg::exp_width-1:0]         exp_b;
    logic [float_fmt_pkg::exp_width-1:0]         exp_r;
    logic [float_fmt_pkg::mant_width-1:0]        frac_a;
    logic [float_fmt_pkg::mant_width-1:0]        frac_b;
    logic signed [float_fmt_pkg::mant_width+1:0] x;
    logic signed [float_fmt_pkg::mant_width+1:0] y;
    logic signed [float_fmt_pkg::mant_width+1:0] s;
    logic [float_fmt_pkg::mant_width:0]          mag;
    sign_a = a[float_fmt_pkg::float_width-1];
    sign_b = b[float_fmt_pkg::float_width-1] ^ (op == arith_unit_pkg::op_fsub);
    exp_a = a[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    exp_b = b[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    frac_a = (exp_a == '0) ? '0 : {1'b1, a[float_fmt_pkg::frac_width-1:0]};
    frac_b = (exp_b == '0) ? '0 : {1'b1, b[float_fmt_pkg::frac_width-1:0]};
    if (exp_a > exp_b) begin
        x = {2'b00, frac_a};
        y = {2'b00, frac_b >> (exp_a - exp_b)};
        exp_r = exp_a;
    end else begin
        x = {2'b00, frac_a >> (exp_b - exp_a)};
        y = {2'b00, frac_b};
        exp_r = exp_b;
    end
    sign_r = (sign_a == sign_b) ? sign_a : 1'b0;
    if (sign_a != sign_b) begin
        if (sign_a) begin
            x = -x;
        end else begin
            y = -y;
        end
    end
    s = x + y;
    if (s[float_fmt_pkg::mant_width+1]) begin
        sign_r = 1'b1;
        s = -s;
    end
    mag = s[float_fmt_pkg::mant_width:0];
    if (mag == '0) begin
        return '0;
    end
    if (mag[float_fmt_pkg::mant_width]) begin
        mag = mag >> 1;
        exp_r = exp_r + 1'b1;
    end
    while (!mag[float_fmt_pkg::mant_width-1]) begin
        mag = mag << 1;
        exp_r = exp_r - 1'b1;
    end
    return {sign_r, exp_r, mag[float_fmt_pkg::frac_width-1:0]};
endfunction

// truncated product, one normalize step.
function automatic logic [float_fmt_pkg::float_width-1:0] ref_float_mul(
    input logic [float_fmt_pkg::float_width-1:0] a,
    input logic [float_fmt_pkg::float_width-1:0] b
);
    logic [float_fmt_pkg::exp_width-1:0]    exp_a;
    logic [float_fmt_pkg::exp_width-1:0]    exp_b;
    logic [float_fmt_pkg::exp_width-1:0]    exp_r;
    logic [float_fmt_pkg::mant_width-1:0]   frac_a;
    logic [float_fmt_pkg::mant_width-1:0]   frac_b;
    logic [2*float_fmt_pkg::mant_width-1:0] prod;
    exp_a = a[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    exp_b = b[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    frac_a = (exp_a == '0) ? '0 : {1'b1, a[float_fmt_pkg::frac_width-1:0]};
    frac_b = (exp_b == '0) ? '0 : {1'b1, b[float_fmt_pkg::frac_width-1:0]};
    prod = frac_a * frac_b;
    if (prod == '0) begin
        return '0;
    end
    exp_r = exp_a + exp_b - (float_fmt_pkg::exp_bias - 1'b1);
    if (!prod[2*float_fmt_pkg::mant_width-1]) begin
        prod = prod << 1;
        exp_r = exp_r - 1'b1;
    end
    return {a[float_fmt_pkg::float_width-1] ^ b[float_fmt_pkg::float_width-1], exp_r,
            prod[2*float_fmt_pkg::mant_width-2 -: float_fmt_pkg::frac_width]};
endfunction

`endif

// ==== arith_unit_tb.sv ====
module arith_unit_tb;

    localparam int num_random = 150;
    localparam int div_latency = 32;

    logic                                 clk;
    logic                                 arst_n;
    logic                                 start;
    arith_unit_pkg::op_e                  op;
    logic [arith_unit_pkg::int_width-1:0] a;
    logic [arith_unit_pkg::int_width-1:0] b;
    logic [arith_unit_pkg::int_width-1:0] result;
    logic                                 ready;

    arith_unit_pkg::op_e                  op_list[$];
    logic [arith_unit_pkg::int_width-1:0] a_list[$];
    logic [arith_unit_pkg::int_width-1:0] b_list[$];

    // operation currently waiting for ready.
    logic                                 in_flight;
    arith_unit_pkg::op_e                  cur_op;
    logic [arith_unit_pkg::int_width-1:0] cur_a;
    logic [arith_unit_pkg::int_width-1:0] cur_b;
    logic [arith_unit_pkg::int_width-1:0] cur_expected;
    int                                   issued;
    int                                   checked;
    int                                   low_cycles;
    logic                                 list_built;
    int                                   i;

    `include "arith_unit_ref.svh"

    arith_unit DUT (
        .clk(clk),
        .arst_n(arst_n),
        .start(start),
        .op(op),
        .a(a),
        .b(b),
        .result(result),
        .ready(ready)
    );

    function automatic logic [arith_unit_pkg::int_width-1:0] expected_result(
        input arith_unit_pkg::op_e                  code,
        input logic [arith_unit_pkg::int_width-1:0] lhs,
        input logic [arith_unit_pkg::int_width-1:0] rhs
    );
        case (code)
            arith_unit_pkg::op_divu, arith_unit_pkg::op_divs: return ref_divide(code, lhs, rhs);
            arith_unit_pkg::op_fadd, arith_unit_pkg::op_fsub: return ref_float_add(code, lhs, rhs);
            default: return ref_float_mul(lhs, rhs);
        endcase
    endfunction

    // normal numbers with exponents 64 to 190.
    function automatic logic [float_fmt_pkg::float_width-1:0] random_float();
        logic [float_fmt_pkg::exp_width-1:0] exponent;
        exponent = 8'(64 + ($urandom % 127));
        return {1'($urandom), exponent, 23'($urandom)};
    endfunction

    task automatic queue_op(
        input arith_unit_pkg::op_e                  code,
        input logic [arith_unit_pkg::int_width-1:0] lhs,
        input logic [arith_unit_pkg::int_width-1:0] rhs
    );
        op_list.push_back(code);
        a_list.push_back(lhs);
        b_list.push_back(rhs);
    endtask

    task automatic build_ops();
        arith_unit_pkg::op_e                  code;
        logic [arith_unit_pkg::int_width-1:0] lhs;
        logic [arith_unit_pkg::int_width-1:0] rhs;
        int                                   n;
        queue_op(arith_unit_pkg::op_divu, 32'hffff_ffff, 32'h0000_0001);
        queue_op(arith_unit_pkg::op_divu, 32'hffff_ffff, 32'hffff_ffff);
        queue_op(arith_unit_pkg::op_divu, 32'h0000_0005, 32'h0000_0007);
        queue_op(arith_unit_pkg::op_divu, 32'h8000_0000, 32'h0000_0003);
        // -100 and -7 in all four sign combinations.
        queue_op(arith_unit_pkg::op_divs, 32'h0000_0064, 32'h0000_0007);
        queue_op(arith_unit_pkg::op_divs, 32'hffff_ff9c, 32'h0000_0007);
        queue_op(arith_unit_pkg::op_divs, 32'h0000_0064, 32'hffff_fff9);
        queue_op(arith_unit_pkg::op_divs, 32'hffff_ff9c, 32'hffff_fff9);
        queue_op(arith_unit_pkg::op_divs, 32'h8000_0000, 32'hffff_ffff);
        queue_op(arith_unit_pkg::op_fadd, 32'h3fc0_0000, 32'h3fc0_0000);
        queue_op(arith_unit_pkg::op_fsub, 32'h3fc0_0000, 32'h3fc0_0000);
        queue_op(arith_unit_pkg::op_fadd, 32'h4049_0fdb, 32'hc049_0fdb);
        queue_op(arith_unit_pkg::op_fsub, 32'h4100_0000, 32'h3f80_0001);
        // long left shift in normalize.
        queue_op(arith_unit_pkg::op_fadd, 32'h3f80_0000, 32'hbf7f_ffff);
        queue_op(arith_unit_pkg::op_fmul, 32'h0000_0000, 32'h3fc0_0000);
        queue_op(arith_unit_pkg::op_fmul, 32'h3fc0_0000, 32'h3fc0_0000);
        queue_op(arith_unit_pkg::op_fmul, 32'hc000_0000, 32'h3f80_0000);
        for (n = 0; n < num_random; n++) begin
            code = arith_unit_pkg::op_e'($urandom % 5);
            if (code == arith_unit_pkg::op_divu || code == arith_unit_pkg::op_divs) begin
                lhs = $urandom;
                // narrow divisors as well as wide ones.
                rhs = $urandom >> ($urandom % 32);
                if (rhs == '0) begin
                    rhs = 32'h0000_0001;
                end
            end else begin
                lhs = random_float();
                rhs = random_float();
            end
            queue_op(code, lhs, rhs);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        void'($urandom(32'h768fd73b));
        arst_n = 1'b1;
        start = 1'b0;
        op = arith_unit_pkg::op_divu;
        a = '0;
        b = '0;
        in_flight = 1'b0;
        issued = 0;
        checked = 0;
        low_cycles = 0;
        list_built = 1'b0;
        build_ops();
        list_built = 1'b1;
        #1 arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        assert (ready) else begin
            $display("mismatch at %0t: ready low after reset, expected high", $time);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        for (i = 0; i < op_list.size(); i++) begin
            wait (checked == issued);
            @(posedge clk);
            #1;
            start = 1'b1;
            op = op_list[i];
            a = a_list[i];
            b = b_list[i];
            @(posedge clk);
            #1;
            start = 1'b0;
            cur_op = op_list[i];
            cur_a = a_list[i];
            cur_b = b_list[i];
            cur_expected = expected_result(op_list[i], a_list[i], b_list[i]);
            low_cycles = 0;
            issued++;
            in_flight = 1'b1;
        end
        wait (checked == issued);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // sampled at the falling edge away from the DUT updates.
    initial begin
        forever begin
            @(negedge clk);
            if (in_flight) begin
                if (!ready) begin
                    low_cycles++;
                end else begin
                    assert (result == cur_expected) else begin
                        $display("mismatch at %0t: %s a=%h b=%h result %h expected %h",
                                 $time, cur_op.name(), cur_a, cur_b, result, cur_expected);
                        $display("TESTBENCH FAILED");
                        $fatal(1);
                    end
                    if (cur_op == arith_unit_pkg::op_divu
                        || cur_op == arith_unit_pkg::op_divs) begin
                        assert (low_cycles == div_latency) else begin
                            $display("mismatch at %0t: %s kept ready low %0d cycles, expected %0d",
                                     $time, cur_op.name(), low_cycles, div_latency);
                            $display("TESTBENCH FAILED");
                            $fatal(1);
                        end
                    end
                    in_flight = 1'b0;
                    checked++;
                end
            end
        end
    end

    initial begin
        wait (list_built);
        repeat (op_list.size() * 40 + 2) @(posedge clk);
        $display("timeout: ready never returned, %0d of %0d operations checked",
                 checked, op_list.size());
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// ==== float_adder.sv ====
module float_adder (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  start,
    input  logic                                  subtract,
    input  logic [float_fmt_pkg::float_width-1:0] a,
    input  logic [float_fmt_pkg::float_width-1:0] b,
    output logic [float_fmt_pkg::float_width-1:0] sum,
    output logic                                  ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_align,
        st_sign,
        st_sum,
        st_norm
    } state_e;

    state_e                                    state;
    logic [float_fmt_pkg::float_width-1:0]     a_q;
    logic [float_fmt_pkg::float_width-1:0]     b_q;
    logic [float_fmt_pkg::exp_width-1:0]       exp_q;
    logic signed [float_fmt_pkg::mant_width+1:0] aligned_a;
    logic signed [float_fmt_pkg::mant_width+1:0] aligned_b;
    logic signed [float_fmt_pkg::mant_width+1:0] raw_sum;
    logic signed [float_fmt_pkg::mant_width+1:0] neg_sum;
    logic [float_fmt_pkg::mant_width:0]        mag;
    logic                                      sum_sign;
    logic                                      sign_q;

    logic                                sign_a;
    logic                                sign_b;
    logic [float_fmt_pkg::exp_width-1:0]  exp_a;
    logic [float_fmt_pkg::exp_width-1:0]  exp_b;
    logic [float_fmt_pkg::mant_width-1:0] frac_a;
    logic [float_fmt_pkg::mant_width-1:0] frac_b;

    assign sign_a = a_q[float_fmt_pkg::float_width-1];
    assign sign_b = b_q[float_fmt_pkg::float_width-1];
    assign exp_a = a_q[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    assign exp_b = b_q[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    // zero exponent reads as zero.
    assign frac_a = (exp_a == '0) ? '0 : {1'b1, a_q[float_fmt_pkg::frac_width-1:0]};
    assign frac_b = (exp_b == '0) ? '0 : {1'b1, b_q[float_fmt_pkg::frac_width-1:0]};

    assign raw_sum = aligned_a + aligned_b;
    assign neg_sum = -raw_sum;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            a_q <= '0;
            b_q <= '0;
            exp_q <= '0;
            aligned_a <= '0;
            aligned_b <= '0;
            mag <= '0;
            sum_sign <= 1'b0;
            sign_q <= 1'b0;
        end else if (start) begin
            a_q <= a;
            b_q <= {b[float_fmt_pkg::float_width-1] ^ subtract,
                    b[float_fmt_pkg::float_width-2:0]};
            state <= st_align;
        end else begin
            case (state)
                st_align: begin
                    // truncating shift of the smaller operand.
                    if (exp_a > exp_b) begin
                        aligned_a <= {2'b00, frac_a};
                        aligned_b <= {2'b00, frac_b >> (exp_a - exp_b)};
                        exp_q <= exp_a;
                    end else begin
                        aligned_a <= {2'b00, frac_a >> (exp_b - exp_a)};
                        aligned_b <= {2'b00, frac_b};
                        exp_q <= exp_b;
                    end
                    state <= st_sign;
                end
                st_sign: begin
                    if (sign_a != sign_b) begin
                        if (sign_a) begin
                            aligned_a <= -aligned_a;
                        end else begin
                            aligned_b <= -aligned_b;
                        end
                        sum_sign <= 1'b0;
                    end else begin
                        sum_sign <= sign_a;
                    end
                    state <= st_sum;
                end
                st_sum: begin
                    if (raw_sum[float_fmt_pkg::mant_width+1]) begin
                        sign_q <= 1'b1;
                        mag <= neg_sum[float_fmt_pkg::mant_width:0];
                    end else begin
                        sign_q <= sum_sign;
                        mag <= raw_sum[float_fmt_pkg::mant_width:0];
                    end
                    state <= st_norm;
                end
                st_norm: begin
                    if (mag[float_fmt_pkg::mant_width]) begin
                        mag <= mag >> 1;
                        exp_q <= exp_q + 1'b1;
                        state <= st_idle;
                    end else if (mag == '0) begin
                        exp_q <= '0;
                        sign_q <= 1'b0;
                        state <= st_idle;
                    end else if (!mag[float_fmt_pkg::mant_width-1]) begin
                        // stays here until the hidden bit is set.
                        mag <= mag << 1;
                        exp_q <= exp_q - 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: ;
            endcase
        end
    end

    assign sum = {sign_q, exp_q, mag[float_fmt_pkg::frac_width-1:0]};
    assign ready = (state == st_idle);

    assert property (@(posedge clk) disable iff (!arst_n)
        state inside {st_idle, st_align, st_sign, st_sum, st_norm});

endmodule

// ==== float_fmt_pkg.sv ====
package float_fmt_pkg;

    // binary32 layout.
    localparam int exp_width = 8;
    localparam int frac_width = 23;
    localparam int float_width = 32;

    // hidden bit included.
    localparam int mant_width = 24;

    localparam logic [exp_width-1:0] exp_bias = 127;

endpackage

// ==== float_multiplier.sv ====
module float_multiplier (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  start,
    input  logic [float_fmt_pkg::float_width-1:0] a,
    input  logic [float_fmt_pkg::float_width-1:0] b,
    output logic [float_fmt_pkg::float_width-1:0] product,
    output logic                                  ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_mult,
        st_norm
    } state_e;

    state_e                                  state;
    logic [float_fmt_pkg::float_width-1:0]   a_q;
    logic [float_fmt_pkg::float_width-1:0]   b_q;
    logic                                    sign_q;
    logic [float_fmt_pkg::exp_width-1:0]     exp_q;
    logic [2*float_fmt_pkg::mant_width-1:0]  prod_q;

    logic [float_fmt_pkg::exp_width-1:0]     exp_a;
    logic [float_fmt_pkg::exp_width-1:0]     exp_b;
    logic [float_fmt_pkg::mant_width-1:0]    frac_a;
    logic [float_fmt_pkg::mant_width-1:0]    frac_b;
    logic                                    mul_start;
    logic                                    mul_ready;
    logic [2*float_fmt_pkg::mant_width-1:0]  mul_product;

    assign exp_a = a_q[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    assign exp_b = b_q[float_fmt_pkg::float_width-2 -: float_fmt_pkg::exp_width];
    assign frac_a = (exp_a == '0) ? '0 : {1'b1, a_q[float_fmt_pkg::frac_width-1:0]};
    assign frac_b = (exp_b == '0) ? '0 : {1'b1, b_q[float_fmt_pkg::frac_width-1:0]};

    assign mul_start = (state == st_setup);

    shift_add_multiplier #(
        .width(float_fmt_pkg::mant_width)
    ) u_frac_mul (
        .clk(clk),
        .arst_n(arst_n),
        .start(mul_start),
        .multiplicand(frac_a),
        .multiplier(frac_b),
        .product(mul_product),
        .ready(mul_ready)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            a_q <= '0;
            b_q <= '0;
            sign_q <= 1'b0;
            exp_q <= '0;
            prod_q <= '0;
        end else if (start) begin
            a_q <= a;
            b_q <= b;
            state <= st_setup;
        end else begin
            case (state)
                st_setup: begin
                    sign_q <= a_q[float_fmt_pkg::float_width-1]
                            ^ b_q[float_fmt_pkg::float_width-1];
                    exp_q <= exp_a + exp_b;
                    state <= st_mult;
                end
                st_mult: begin
                    if (mul_ready) begin
                        prod_q <= mul_product;
                        // product carries one extra integer bit.
                        exp_q <= exp_q - (float_fmt_pkg::exp_bias - 1'b1);
                        state <= st_norm;
                    end
                end
                st_norm: begin
                    if (prod_q == '0) begin
                        exp_q <= '0;
                        sign_q <= 1'b0;
                    end else if (!prod_q[2*float_fmt_pkg::mant_width-1]) begin
                        prod_q <= prod_q << 1;
                        exp_q <= exp_q - 1'b1;
                    end
                    state <= st_idle;
                end
                default: ;
            endcase
        end
    end

    assign product = {sign_q, exp_q,
                      prod_q[2*float_fmt_pkg::mant_width-2 -: float_fmt_pkg::frac_width]};
    assign ready = (state == st_idle);

endmodule

// ==== int_divider.sv ====
module int_divider (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 start,
    input  logic                                 is_signed,
    input  logic [arith_unit_pkg::int_width-1:0] dividend,
    input  logic [arith_unit_pkg::int_width-1:0] divisor,
    output logic [arith_unit_pkg::int_width-1:0] quotient,
    output logic                                 ready
);

    logic [arith_unit_pkg::iter_count_width-1:0] count;
    logic [arith_unit_pkg::int_width-1:0]        divisor_q;
    logic [2*arith_unit_pkg::int_width-1:0]      acc;
    logic [arith_unit_pkg::int_width+1:0]        diff;
    logic                                        negate_q;

    // upper half is the partial remainder, lower half collects quotient bits.
    assign diff = {1'b0, acc[2*arith_unit_pkg::int_width-1:arith_unit_pkg::int_width-1]}
                - {2'b00, divisor_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            divisor_q <= '0;
            acc <= '0;
            negate_q <= 1'b0;
        end else if (start) begin
            count <= arith_unit_pkg::int_width[arith_unit_pkg::iter_count_width-1:0];
            acc <= {{arith_unit_pkg::int_width{1'b0}},
                    (is_signed && dividend[arith_unit_pkg::int_width-1]) ? -dividend
                                                                          : dividend};
            divisor_q <= (is_signed && divisor[arith_unit_pkg::int_width-1]) ? -divisor
                                                                              : divisor;
            negate_q <= is_signed && (dividend[arith_unit_pkg::int_width-1]
                                      ^ divisor[arith_unit_pkg::int_width-1]);
        end else if (count != '0) begin
            count <= count - 1'b1;
            // borrow means the divisor did not fit.
            if (diff[arith_unit_pkg::int_width+1]) begin
                acc <= {acc[2*arith_unit_pkg::int_width-2:0], 1'b0};
            end else begin
                acc <= {diff[arith_unit_pkg::int_width-1:0],
                        acc[arith_unit_pkg::int_width-2:0], 1'b1};
            end
        end
    end

    assign ready = (count == '0);
    assign quotient = negate_q ? -acc[arith_unit_pkg::int_width-1:0]
                               : acc[arith_unit_pkg::int_width-1:0];

    assert property (@(posedge clk) disable iff (!arst_n)
        count <= arith_unit_pkg::int_width);

    assert property (@(posedge clk) disable iff (!arst_n)
        start |=> !ready);

endmodule

// ==== shift_add_multiplier.sv ====
module shift_add_multiplier #(
    parameter int width = 24
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic [width-1:0]   multiplicand,
    input  logic [width-1:0]   multiplier,
    output logic [2*width-1:0] product,
    output logic               ready
);

    // one bit per step, top bit set when done.
    logic [width:0]     state;
    logic [width-1:0]   mcand_q;
    logic [width-1:0]   mplier_q;
    logic [2*width-1:0] acc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= {1'b1, {width{1'b0}}};
            mcand_q <= '0;
            mplier_q <= '0;
            acc <= '0;
        end else if (start) begin
            state <= {{width{1'b0}}, 1'b1};
            mcand_q <= multiplicand;
            mplier_q <= multiplier;
            acc <= '0;
        end else if (!ready) begin
            // msb first, so double before adding.
            acc <= {acc[2*width-2:0], 1'b0}
                 + (mplier_q[width-1] ? {{width{1'b0}}, mcand_q} : '0);
            mplier_q <= mplier_q << 1;
            state <= state << 1;
        end
    end

    assign ready = state[width];
    assign product = acc;

    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(state));

endmodule
